// File: dv/mcu_periph_checker.sv
`timescale 1ns/10ps

module mcu_periph_checker (
	input logic clk_sys,
	input logic reset_n,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arvalid,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic target_dataslot_read,
	input logic target_dataslot_write
);
	// master side holds its request until taken
	a_aw_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
	a_w_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
	a_ar_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		arvalid && !arready |=> arvalid) else $error("arvalid dropped before arready");
	// responses held until the master takes them
	a_b_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
	a_r_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	a_reset: assert property (@(posedge clk_sys) !reset_n |-> !bvalid && !rvalid)
		else $error("response valid during reset");

	// target command pulses, one cycle each
	a_rd_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_read |=> !target_dataslot_read)
		else $error("target_dataslot_read longer than one cycle");
	a_wr_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_write |=> !target_dataslot_write)
		else $error("target_dataslot_write longer than one cycle");
endmodule

bind mcu_periph_top mcu_periph_checker u_chk (.*);

// File: dv/mcu_periph_monitor.sv
`timescale 1ns/10ps

module mcu_periph_monitor (
	input logic                   clk_sys,
	input logic                   reset_n,
	input logic                   rvalid,
	input logic                   rready,
	input mcu_bus_pkg::axi_data_t rdata,
	input mcu_bus_pkg::axi_resp_t rresp,
	input logic                   target_dataslot_read,
	input logic                   target_dataslot_write,
	input logic                   io_strobe
);
	int err_count   = 0;
	int check_count = 0;
	int rd_pulses   = 0;   // target_dataslot_read cycles seen
	int wr_pulses   = 0;
	int stb_cycles  = 0;   // io_strobe high cycles

	// expected read responses, in bus order
	string       exp_name[$];
	logic [31:0] exp_data[$];
	logic [1:0]  exp_resp[$];
	logic        exp_chk[$];   // 0 when only rresp is known

	task automatic report_error(input string msg);
		err_count++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic expect_read(input string name, input logic [31:0] data,
		input logic [1:0] resp, input logic chk);
		exp_name.push_back(name);
		exp_data.push_back(data);
		exp_resp.push_back(resp);
		exp_chk.push_back(chk);
	endtask

	always @(posedge clk_sys) begin
		if (reset_n && target_dataslot_read)
			rd_pulses++;
		if (reset_n && target_dataslot_write)
			wr_pulses++;
		if (reset_n && io_strobe)
			stb_cycles++;
	end

	// read data is stable at the falling edge
	always @(negedge clk_sys) begin
		if (reset_n && rvalid && rready) begin
			if (exp_name.size() == 0) begin
				report_error("read response arrived with no read outstanding");
			end else begin
				check_value({exp_name[0], " rresp"}, 32'(rresp), 32'(exp_resp[0]));
				if (exp_chk[0])
					check_value({exp_name[0], " rdata"}, rdata, exp_data[0]);
				void'(exp_name.pop_front());
				void'(exp_data.pop_front());
				void'(exp_resp.pop_front());
				void'(exp_chk.pop_front());
			end
		end
	end
endmodule

// File: dv/mcu_periph_tb.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module mcu_periph_tb;
	import mcu_bus_pkg::*;
	import mcu_periph_pkg::*;

	localparam int n_trans        = 80;   // bus transactions, worst case
	localparam int timeout_cycles = n_trans * 200 + 500;
	localparam axi_addr_t page    = {`MCU_PAGE_TAG, 16'h0000};

	logic clk_sys = 1'b0;
	logic reset_n;
	axi_addr_t awaddr, araddr;
	axi_data_t wdata, rdata;
	axi_resp_t bresp, rresp;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic dataslot_update, irq, reset_out;
	slot_id_t dataslot_update_id, target_dataslot_id;
	slot_word_t dataslot_update_size;
	logic target_dataslot_read, target_dataslot_write;
	logic target_dataslot_ack, target_dataslot_done;
	slot_err_t target_dataslot_err;
	slot_word_t target_dataslot_bridgeaddr, target_dataslot_length, target_dataslot_slotoffset;
	io_word_t io_dout, io_din;
	logic io_wide, io_wait, io_strobe, io_fpga, io_uio;

	// shadow of the writable state
	slot_id_t   sh_id, sh_upd_id;
	slot_word_t sh_bridge, sh_len, sh_ofs, sh_upd_size;
	logic       sh_reset, sh_irq;

	logic [31:0] r, r2, d, t0;
	int n_rd, n_wr, n_stb;

	always #5 clk_sys = ~clk_sys;

	mcu_periph_top #(.tick_cycles(20)) dut (.*);
	mcu_periph_monitor u_mon (.*);

	function automatic axi_data_t ref_read(input axi_addr_t a);
		if (a[31:16] != `MCU_PAGE_TAG)
			return '0;   // outside the page
		case (a[7:0])
			`MCU_OFS_SLOT_ID:     return {16'd0, sh_id};
			`MCU_OFS_SLOT_BRIDGE: return sh_bridge;
			`MCU_OFS_SLOT_LEN:    return sh_len;
			`MCU_OFS_SLOT_OFFSET: return sh_ofs;
			`MCU_OFS_SLOT_CTRL:
				return {27'd0, target_dataslot_ack, target_dataslot_done, target_dataslot_err};
			`MCU_OFS_RESET:       return {31'd0, sh_reset};
			`MCU_OFS_IRQ:         return {31'd0, sh_irq};
			`MCU_OFS_UPD_ID:      return {16'd0, sh_upd_id};
			`MCU_OFS_UPD_SIZE:    return sh_upd_size;
			default:              return '0;
		endcase
	endfunction

	function automatic axi_resp_t ref_resp(input axi_addr_t a);
		return (a[31:16] == `MCU_PAGE_TAG) ? OKAY : SLVERR;
	endfunction

	task automatic write_addr(input axi_addr_t a, input axi_data_t v);
		awaddr  = a;
		wdata   = v;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do @(negedge clk_sys); while (!awready);
		u_mon.check_value("wready", 32'(wready), 32'h1);   // taken with the address
		@(posedge clk_sys);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task automatic write_resp(input axi_resp_t exp);
		do @(negedge clk_sys); while (!(bvalid && bready));
		u_mon.check_value("bresp", 32'(bresp), 32'(exp));
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_reg(input axi_addr_t a, input axi_data_t v);
		write_addr(a, v);
		write_resp(ref_resp(a));
		if (a[31:16] == `MCU_PAGE_TAG) begin
			case (a[7:0])
				`MCU_OFS_SLOT_ID:     sh_id = v[15:0];
				`MCU_OFS_SLOT_BRIDGE: sh_bridge = v;
				`MCU_OFS_SLOT_LEN:    sh_len = v;
				`MCU_OFS_SLOT_OFFSET: sh_ofs = v;
				`MCU_OFS_RESET:       sh_reset = v[0];
				default: ;
			endcase
		end
	endtask

	task automatic read_addr(input axi_addr_t a, input axi_data_t exp, input logic chk);
		u_mon.expect_read($sformatf("rdata@%h", a), exp, ref_resp(a), chk);
		araddr  = a;
		arvalid = 1'b1;
		do @(negedge clk_sys); while (!arready);
		@(posedge clk_sys);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic read_data(output axi_data_t v);
		do @(negedge clk_sys); while (!(rvalid && rready));
		v = rdata;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_read(input axi_addr_t a);
		axi_data_t v;
		read_addr(a, ref_read(a), 1'b1);
		read_data(v);
	endtask

	task automatic read_raw(input axi_addr_t a, output axi_data_t v);
		read_addr(a, '0, 1'b0);
		read_data(v);
	endtask

	// poll the hps word until io_ack matches the clk bit, wait jittered
	task automatic poll_hps_ack(input logic clk_bit);
		axi_data_t v;
		int n;
		n = 0;
		v = '0;
		while (n < 20 && (n == 0 || v[`MCU_HPS_ACK_BIT] != clk_bit)) begin
			io_wait = 1'($urandom);
			read_raw(page | `MCU_OFS_HPS, v);
			n++;
		end
		io_wait = 1'b0;
		if (v[`MCU_HPS_ACK_BIT] != clk_bit)
			u_mon.report_error("io_ack never followed the written clk bit");
		u_mon.check_value("hps io_din", 32'(v[15:0]), 32'(io_din));
		u_mon.check_value("hps io_wide", 32'(v[`MCU_HPS_WIDE_BIT]), 32'(io_wide));
	endtask

	initial begin
		#(timeout_cycles * 10);
		$display("watchdog expired after %0d cycles, DUT stopped responding", timeout_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h202b));
		reset_n = 1'b0;
		{awaddr, araddr, wdata} = '0;
		{awvalid, wvalid, arvalid} = '0;
		bready = 1'b1;
		rready = 1'b1;
		dataslot_update = 1'b0;
		dataslot_update_id = '0;
		dataslot_update_size = '0;
		{target_dataslot_ack, target_dataslot_done, target_dataslot_err} = '0;
		io_din = '0;
		io_wide = 1'b0;
		io_wait = 1'b0;
		{sh_id, sh_upd_id, sh_bridge, sh_len, sh_ofs, sh_upd_size} = '0;
		{sh_reset, sh_irq} = '0;
		repeat (5) @(posedge clk_sys);
		#1 reset_n = 1'b1;

		// command registers round trip
		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			write_reg(page | (`MCU_OFS_SLOT_ID + 8'(4 * i)), r);
			check_read(page | (`MCU_OFS_SLOT_ID + 8'(4 * i)));
		end
		@(negedge clk_sys);
		u_mon.check_value("target_dataslot_id", 32'(target_dataslot_id), 32'(sh_id));
		u_mon.check_value("target_dataslot_bridgeaddr", target_dataslot_bridgeaddr, sh_bridge);
		u_mon.check_value("target_dataslot_length", target_dataslot_length, sh_len);
		u_mon.check_value("target_dataslot_slotoffset", target_dataslot_slotoffset, sh_ofs);
		@(posedge clk_sys);
		#1;

		// command pulses and status word
		r = $urandom;
		{target_dataslot_ack, target_dataslot_done, target_dataslot_err} = r[4:0];
		n_rd = u_mon.rd_pulses;
		n_wr = u_mon.wr_pulses;
		write_reg(page | `MCU_OFS_SLOT_CTRL, 32'h1);
		@(negedge clk_sys);
		u_mon.check_value("read pulses", 32'(u_mon.rd_pulses), 32'(n_rd + 1));
		u_mon.check_value("write pulses", 32'(u_mon.wr_pulses), 32'(n_wr));
		@(posedge clk_sys);
		#1;
		write_reg(page | `MCU_OFS_SLOT_CTRL, 32'h2);
		@(negedge clk_sys);
		u_mon.check_value("read pulses", 32'(u_mon.rd_pulses), 32'(n_rd + 1));
		u_mon.check_value("write pulses", 32'(u_mon.wr_pulses), 32'(n_wr + 1));
		@(posedge clk_sys);
		#1;
		check_read(page | `MCU_OFS_SLOT_CTRL);

		// update capture and irq
		r = $urandom;
		r2 = $urandom;
		dataslot_update_id = r[15:0];
		dataslot_update_size = r2;
		dataslot_update = 1'b1;
		@(posedge clk_sys);
		#1 dataslot_update = 1'b0;
		sh_upd_id = r[15:0];
		sh_upd_size = r2;
		sh_irq = 1'b1;
		@(negedge clk_sys);
		u_mon.check_value("irq", 32'(irq), 32'h1);
		@(posedge clk_sys);
		#1;
		check_read(page | `MCU_OFS_UPD_ID);
		check_read(page | `MCU_OFS_UPD_SIZE);
		check_read(page | `MCU_OFS_IRQ);
		sh_irq = 1'b0;
		u_mon.check_value("irq", 32'(irq), 32'h0);
		check_read(page | `MCU_OFS_IRQ);

		// wrong page tag
		write_reg(32'h1234_0000 | `MCU_OFS_SLOT_ID, $urandom);
		check_read(32'h1234_0000 | `MCU_OFS_SLOT_ID);
		check_read(page | `MCU_OFS_SLOT_ID);

		// write back-pressure, second write waits for bready
		bready = 1'b0;
		write_addr(page | `MCU_OFS_SLOT_LEN, 32'h1111_2222);
		sh_len = 32'h1111_2222;
		fork
			begin
				repeat (3) begin
					@(negedge clk_sys);
					u_mon.check_value("bvalid", 32'(bvalid), 32'h1);
					u_mon.check_value("awready", 32'(awready), 32'h0);
				end
				@(posedge clk_sys);
				#1 bready = 1'b1;
			end
			write_addr(page | `MCU_OFS_SLOT_OFFSET, 32'h3333_4444);
		join
		write_resp(OKAY);
		sh_ofs = 32'h3333_4444;

		// read back-pressure
		rready = 1'b0;
		read_addr(page | `MCU_OFS_SLOT_LEN, sh_len, 1'b1);
		fork
			begin
				repeat (3) begin
					@(negedge clk_sys);
					u_mon.check_value("rvalid", 32'(rvalid), 32'h1);
					u_mon.check_value("arready", 32'(arready), 32'h0);
				end
				@(posedge clk_sys);
				#1 rready = 1'b1;
			end
			read_addr(page | `MCU_OFS_SLOT_OFFSET, sh_ofs, 1'b1);
		join
		read_data(d);

		// hps port, clk high with ss0 and a random ss2
		r = $urandom;
		r2 = $urandom;
		io_din = r2[15:0];
		io_wide = r2[16];
		io_wait = 1'b1;   // far side stalled until the poll lets go
		n_stb = u_mon.stb_cycles;
		write_reg(page | `MCU_OFS_HPS, {11'd0, r[16], 1'b0, 1'b1, 1'b1, 1'b0, r[15:0]});
		@(negedge clk_sys);
		u_mon.check_value("io_dout", 32'(io_dout), 32'(r[15:0]));
		u_mon.check_value("io_fpga", 32'(io_fpga), 32'h1);
		u_mon.check_value("io_uio", 32'(io_uio), 32'(r[16]));
		if (u_mon.stb_cycles == n_stb)
			u_mon.report_error("io_strobe never rose after the clk bit was set");
		@(posedge clk_sys);
		#1;
		poll_hps_ack(1'b1);
		io_wait = 1'b1;
		write_reg(page | `MCU_OFS_HPS, {11'd0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, r[15:0]});
		@(negedge clk_sys);
		u_mon.check_value("io_fpga", 32'(io_fpga), 32'h0);   // ss1 masks
		u_mon.check_value("io_uio", 32'(io_uio), 32'h0);
		@(posedge clk_sys);
		#1;
		poll_hps_ack(1'b0);

		// timer, 100 cycles at 20 per tick
		read_raw(page | `MCU_OFS_TIMER, t0);
		repeat (100) @(posedge clk_sys);
		#1;
		read_raw(page | `MCU_OFS_TIMER, d);
		if (d - t0 < 32'd4 || d - t0 > 32'd6)
			u_mon.report_error($sformatf("timer advanced by %0d over 100 cycles", d - t0));

		// reset_out
		write_reg(page | `MCU_OFS_RESET, 32'h1);
		u_mon.check_value("reset_out", 32'(reset_out), 32'h1);
		check_read(page | `MCU_OFS_RESET);
		write_reg(page | `MCU_OFS_RESET, 32'h0);
		u_mon.check_value("reset_out", 32'(reset_out), 32'h0);

		@(negedge clk_sys);
		$display("checks: %0d  errors: %0d", u_mon.check_count, u_mon.err_count);
		if (u_mon.err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

// File: hw/hps_io_port.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module hps_io_port (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	input  logic                     hps_wr,
	input  mcu_bus_pkg::axi_data_t   hps_wdata,
	output logic [17:0]              hps_status,   // ack, wide, din
	output mcu_periph_pkg::io_word_t io_dout,
	input  mcu_periph_pkg::io_word_t io_din,
	input  logic                     io_wide,      // 1 for 16 bit transfers
	input  logic                     io_wait,
	output logic                     io_strobe,
	output logic                     io_fpga,
	output logic                     io_uio
);
	logic io_clk;    // software driven clock bit
	logic io_ss0;
	logic io_ss1;
	logic io_ss2;
	logic rack;      // clk as seen by the far side
	logic io_ack;

	// output latches
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			io_dout <= '0;
			io_clk  <= 1'b0;
			io_ss0  <= 1'b0;
			io_ss1  <= 1'b0;
			io_ss2  <= 1'b0;
		end else if (hps_wr) begin
			io_dout <= hps_wdata[15:0];
			io_clk  <= hps_wdata[`MCU_HPS_CLK_BIT];
			io_ss0  <= hps_wdata[`MCU_HPS_SS0_BIT];
			io_ss1  <= hps_wdata[`MCU_HPS_SS1_BIT];
			io_ss2  <= hps_wdata[`MCU_HPS_SS2_BIT];
		end
	end

	// ss1 masks both selects
	assign io_fpga = io_ss0 & ~io_ss1;   // command to the core
	assign io_uio  = io_ss2 & ~io_ss1;   // broadcast

	// strobe stays up until the clk edge has been taken
	assign io_strobe = io_clk & ~rack;

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else if (!io_wait || io_strobe) begin
			rack   <= io_clk;
			io_ack <= rack;   // one stage behind rack
		end
	end

	always_comb begin
		hps_status                    = '0;
		hps_status[15:0]              = io_din;
		hps_status[`MCU_HPS_WIDE_BIT] = io_wide;
		hps_status[`MCU_HPS_ACK_BIT]  = io_ack;
	end

endmodule

// File: hw/mcu_axil_slave.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module mcu_axil_slave (
	input  logic                     clk_sys,
	input  logic                     reset_n,
	// write address and data
	input  mcu_bus_pkg::axi_addr_t   awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  mcu_bus_pkg::axi_data_t   wdata,
	input  logic                     wvalid,
	output logic                     wready,
	// write response
	output mcu_bus_pkg::axi_resp_t   bresp,
	output logic                     bvalid,
	input  logic                     bready,
	// read address and data
	input  mcu_bus_pkg::axi_addr_t   araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output mcu_bus_pkg::axi_data_t   rdata,
	output mcu_bus_pkg::axi_resp_t   rresp,
	output logic                     rvalid,
	input  logic                     rready,
	// register file strobes
	output logic                     reg_wr,
	output logic                     reg_rd,
	output mcu_bus_pkg::reg_offset_t reg_offset,
	output mcu_bus_pkg::axi_data_t   reg_wdata,
	input  mcu_bus_pkg::axi_data_t   reg_rdata
);
	import mcu_bus_pkg::*;

	axil_state_t wr_state;
	axil_state_t rd_state;
	logic        wr_hs;       // aw and w taken this edge
	logic        rd_hs;       // ar taken this edge
	logic        wr_tag_ok;
	logic        rd_tag_ok;

	assign wr_tag_ok = (awaddr[31:16] == `MCU_PAGE_TAG);
	assign rd_tag_ok = (araddr[31:16] == `MCU_PAGE_TAG);

	// address and data accepted on the same edge, never one without the other
	assign wr_hs = (wr_state == IDLE) && awvalid && wvalid;
	// write owns the shared offset port, a colliding read slips one cycle
	assign rd_hs = (rd_state == IDLE) && arvalid && !wr_hs;

	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = rd_hs;
	assign bvalid  = (wr_state == RESP);   // blocks new writes until bready
	assign rvalid  = (rd_state == RESP);

	// strobes only for accesses inside the page
	assign reg_wr     = wr_hs && wr_tag_ok;
	assign reg_rd     = rd_hs && rd_tag_ok;
	assign reg_offset = wr_hs ? awaddr[7:0] : araddr[7:0];
	assign reg_wdata  = wdata;

	// write channel
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			wr_state <= IDLE;
			bresp    <= OKAY;
		end else begin
			case (wr_state)
				IDLE: begin
					if (wr_hs) begin
						wr_state <= RESP;
						bresp    <= wr_tag_ok ? OKAY : SLVERR;
					end
				end
				RESP: begin
					if (bready)
						wr_state <= IDLE;
				end
				default: wr_state <= IDLE;
			endcase
		end
	end

	// read channel
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			rd_state <= IDLE;
			rresp    <= OKAY;
		end else begin
			case (rd_state)
				IDLE: begin
					if (rd_hs) begin
						rd_state <= RESP;
						rresp    <= rd_tag_ok ? OKAY : SLVERR;
					end
				end
				RESP: begin
					if (rready)
						rd_state <= IDLE;
				end
				default: rd_state <= IDLE;
			endcase
		end
	end

	// read data captured with the address, held while rvalid
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n)
			rdata <= '0;
		else if (rd_hs)
			rdata <= rd_tag_ok ? reg_rdata : '0;   // zero on bad tag
	end

endmodule

// File: hw/mcu_bus_pkg.sv
package mcu_bus_pkg;

	// axi4-lite side
	typedef logic [31:0] axi_addr_t;   // byte address
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t OKAY   = 2'b00;
	localparam axi_resp_t SLVERR = 2'b10;   // page tag mismatch

	// word offset inside the peripheral page, address bits 7:0
	typedef logic [7:0] reg_offset_t;

	// one machine per channel
	typedef enum logic {
		IDLE,   // waiting for address
		RESP    // response held until master takes it
	} axil_state_t;

endpackage

// File: hw/mcu_defines.svh
`ifndef MCU_DEFINES_SVH
`define MCU_DEFINES_SVH

// upper address half that selects the peripheral page
`define MCU_PAGE_TAG        16'hFFFF

// word offsets within the page
`define MCU_OFS_SLOT_ID     8'h80
`define MCU_OFS_SLOT_BRIDGE 8'h84
`define MCU_OFS_SLOT_LEN    8'h88
`define MCU_OFS_SLOT_OFFSET 8'h8C
`define MCU_OFS_SLOT_CTRL   8'h90   // write starts a command, read gives status
`define MCU_OFS_RESET       8'hA4
`define MCU_OFS_IRQ         8'hB0   // read clears
`define MCU_OFS_UPD_ID      8'hB4
`define MCU_OFS_UPD_SIZE    8'hB8
`define MCU_OFS_TIMER       8'hC8
`define MCU_OFS_HPS         8'hD0

// hps word fields, write side then read side
`define MCU_HPS_CLK_BIT     17
`define MCU_HPS_SS0_BIT     18
`define MCU_HPS_SS1_BIT     19
`define MCU_HPS_SS2_BIT     20
`define MCU_HPS_ACK_BIT     17
`define MCU_HPS_WIDE_BIT    16

`define MCU_TICK_CYCLES     28400   // one tick at 28.4 MHz

`endif

// File: hw/mcu_periph_pkg.sv
package mcu_periph_pkg;

	// dataslot fields seen by the target interface
	typedef logic [15:0] slot_id_t;
	typedef logic [31:0] slot_word_t;   // length, offset, address, size
	typedef logic [2:0]  slot_err_t;    // zero is ok

	// hps parallel port
	typedef logic [15:0] io_word_t;     // 8 bit transfers use the low byte

endpackage

// File: hw/mcu_periph_top.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module mcu_periph_top #(
	parameter int tick_cycles = `MCU_TICK_CYCLES
) (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	// axi4-lite slave
	input  mcu_bus_pkg::axi_addr_t     awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  mcu_bus_pkg::axi_data_t     wdata,
	input  logic                       wvalid,
	output logic                       wready,
	output mcu_bus_pkg::axi_resp_t     bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  mcu_bus_pkg::axi_addr_t     araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output mcu_bus_pkg::axi_data_t     rdata,
	output mcu_bus_pkg::axi_resp_t     rresp,
	output logic                       rvalid,
	input  logic                       rready,
	// dataslot update and misc
	input  logic                       dataslot_update,
	input  mcu_periph_pkg::slot_id_t   dataslot_update_id,
	input  mcu_periph_pkg::slot_word_t dataslot_update_size,
	output logic                       irq,
	output logic                       reset_out,
	// target dataslot
	output logic                       target_dataslot_read,
	output logic                       target_dataslot_write,
	input  logic                       target_dataslot_ack,
	input  logic                       target_dataslot_done,
	input  mcu_periph_pkg::slot_err_t  target_dataslot_err,
	output mcu_periph_pkg::slot_id_t   target_dataslot_id,
	output mcu_periph_pkg::slot_word_t target_dataslot_bridgeaddr,
	output mcu_periph_pkg::slot_word_t target_dataslot_length,
	output mcu_periph_pkg::slot_word_t target_dataslot_slotoffset,
	// hps parallel port
	output mcu_periph_pkg::io_word_t   io_dout,
	input  mcu_periph_pkg::io_word_t   io_din,
	input  logic                       io_wide,
	input  logic                       io_wait,
	output logic                       io_strobe,
	output logic                       io_fpga,
	output logic                       io_uio
);
	import mcu_bus_pkg::*;
	import mcu_periph_pkg::*;

	logic        reg_wr;
	logic        reg_rd;
	reg_offset_t reg_offset;
	axi_data_t   reg_wdata;
	axi_data_t   reg_rdata;
	logic        hps_wr;
	axi_data_t   hps_wdata;
	logic [17:0] hps_status;
	slot_word_t  timer_count;

	mcu_axil_slave u_axil (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_offset (reg_offset),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata)
	);

	mcu_reg_file u_regs (
		.clk_sys                    (clk_sys),
		.reset_n                    (reset_n),
		.reg_wr                     (reg_wr),
		.reg_rd                     (reg_rd),
		.reg_offset                 (reg_offset),
		.reg_wdata                  (reg_wdata),
		.reg_rdata                  (reg_rdata),
		.timer_count                (timer_count),
		.hps_wr                     (hps_wr),
		.hps_wdata                  (hps_wdata),
		.hps_status                 (hps_status),
		.dataslot_update            (dataslot_update),
		.dataslot_update_id         (dataslot_update_id),
		.dataslot_update_size       (dataslot_update_size),
		.irq                        (irq),
		.reset_out                  (reset_out),
		.target_dataslot_read       (target_dataslot_read),
		.target_dataslot_write      (target_dataslot_write),
		.target_dataslot_ack        (target_dataslot_ack),
		.target_dataslot_done       (target_dataslot_done),
		.target_dataslot_err        (target_dataslot_err),
		.target_dataslot_id         (target_dataslot_id),
		.target_dataslot_bridgeaddr (target_dataslot_bridgeaddr),
		.target_dataslot_length     (target_dataslot_length),
		.target_dataslot_slotoffset (target_dataslot_slotoffset)
	);

	hps_io_port u_hps (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.hps_wr     (hps_wr),
		.hps_wdata  (hps_wdata),
		.hps_status (hps_status),
		.io_dout    (io_dout),
		.io_din     (io_din),
		.io_wide    (io_wide),
		.io_wait    (io_wait),
		.io_strobe  (io_strobe),
		.io_fpga    (io_fpga),
		.io_uio     (io_uio)
	);

	ms_timer #(
		.tick_cycles (tick_cycles)
	) u_timer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.timer_count (timer_count)
	);

endmodule

// File: hw/mcu_reg_file.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module mcu_reg_file (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	// from the bus slave
	input  logic                       reg_wr,
	input  logic                       reg_rd,
	input  mcu_bus_pkg::reg_offset_t   reg_offset,
	input  mcu_bus_pkg::axi_data_t     reg_wdata,
	output mcu_bus_pkg::axi_data_t     reg_rdata,
	input  mcu_periph_pkg::slot_word_t timer_count,
	// hps port
	output logic                       hps_wr,
	output mcu_bus_pkg::axi_data_t     hps_wdata,
	input  logic [17:0]                hps_status,
	// dataslot update side
	input  logic                       dataslot_update,
	input  mcu_periph_pkg::slot_id_t   dataslot_update_id,
	input  mcu_periph_pkg::slot_word_t dataslot_update_size,
	output logic                       irq,
	output logic                       reset_out,
	// target dataslot commands
	output logic                       target_dataslot_read,
	output logic                       target_dataslot_write,
	input  logic                       target_dataslot_ack,
	input  logic                       target_dataslot_done,
	input  mcu_periph_pkg::slot_err_t  target_dataslot_err,
	output mcu_periph_pkg::slot_id_t   target_dataslot_id,
	output mcu_periph_pkg::slot_word_t target_dataslot_bridgeaddr,
	output mcu_periph_pkg::slot_word_t target_dataslot_length,
	output mcu_periph_pkg::slot_word_t target_dataslot_slotoffset
);
	import mcu_bus_pkg::*;
	import mcu_periph_pkg::*;

	slot_id_t   upd_id;     // last update id
	slot_word_t upd_size;
	logic       irq_rd;     // status read of the irq word

	assign irq_rd = reg_rd && (reg_offset == `MCU_OFS_IRQ);

	// hps word goes straight through to the port latches
	assign hps_wr    = reg_wr && (reg_offset == `MCU_OFS_HPS);
	assign hps_wdata = reg_wdata;

	// command registers and pulses
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			target_dataslot_id         <= '0;
			target_dataslot_bridgeaddr <= '0;
			target_dataslot_length     <= '0;
			target_dataslot_slotoffset <= '0;
			target_dataslot_read       <= 1'b0;
			target_dataslot_write      <= 1'b0;
			reset_out                  <= 1'b0;
		end else begin
			target_dataslot_read  <= 1'b0;   // single cycle pulses
			target_dataslot_write <= 1'b0;
			if (reg_wr) begin
				case (reg_offset)
					`MCU_OFS_SLOT_ID:     target_dataslot_id <= reg_wdata[15:0];
					`MCU_OFS_SLOT_BRIDGE: target_dataslot_bridgeaddr <= reg_wdata;
					`MCU_OFS_SLOT_LEN:    target_dataslot_length <= reg_wdata;
					`MCU_OFS_SLOT_OFFSET: target_dataslot_slotoffset <= reg_wdata;
					`MCU_OFS_SLOT_CTRL: begin
						target_dataslot_read  <= reg_wdata[0];
						target_dataslot_write <= reg_wdata[1];
					end
					`MCU_OFS_RESET:       reset_out <= reg_wdata[0];
					default: ;   // read-only or unmapped
				endcase
			end
		end
	end

	// update capture, irq held until software reads it
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			upd_id   <= '0;
			upd_size <= '0;
			irq      <= 1'b0;
		end else begin
			if (dataslot_update) begin
				upd_id   <= dataslot_update_id;
				upd_size <= dataslot_update_size;
				irq      <= 1'b1;   // new update wins over a clearing read
			end else if (irq_rd) begin
				irq <= 1'b0;
			end
		end
	end

	// read mux, same cycle as the strobe
	always_comb begin
		case (reg_offset)
			`MCU_OFS_SLOT_ID:     reg_rdata = {16'd0, target_dataslot_id};
			`MCU_OFS_SLOT_BRIDGE: reg_rdata = target_dataslot_bridgeaddr;
			`MCU_OFS_SLOT_LEN:    reg_rdata = target_dataslot_length;
			`MCU_OFS_SLOT_OFFSET: reg_rdata = target_dataslot_slotoffset;
			`MCU_OFS_SLOT_CTRL: begin
				// ack bit 4, done bit 3, err 2..0
				reg_rdata = {27'd0, target_dataslot_ack, target_dataslot_done,
					target_dataslot_err};
			end
			`MCU_OFS_RESET:       reg_rdata = {31'd0, reset_out};
			`MCU_OFS_IRQ:         reg_rdata = {31'd0, irq};
			`MCU_OFS_UPD_ID:      reg_rdata = {16'd0, upd_id};
			`MCU_OFS_UPD_SIZE:    reg_rdata = upd_size;
			`MCU_OFS_TIMER:       reg_rdata = timer_count;
			`MCU_OFS_HPS:         reg_rdata = {14'd0, hps_status};
			default:              reg_rdata = '0;
		endcase
	end

endmodule

// File: hw/ms_timer.sv
`timescale 1ns/10ps
`include "mcu_defines.svh"

module ms_timer #(
	parameter int tick_cycles = `MCU_TICK_CYCLES
) (
	input  logic                       clk_sys,
	input  logic                       reset_n,
	output mcu_periph_pkg::slot_word_t timer_count
);
	// prescaler wide enough for tick_cycles-1
	localparam int presc_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

	logic [presc_w-1:0] presc;
	logic               tick;   // last cycle of a tick period

	assign tick = (presc == presc_w'(tick_cycles - 1));

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			presc       <= '0;
			timer_count <= '0;
		end else begin
			if (tick) begin
				presc       <= '0;
				timer_count <= timer_count + 1'b1;   // free running, wraps
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

endmodule

// File: mcu_periph_top.f
+incdir+hw
hw/mcu_bus_pkg.sv
hw/mcu_periph_pkg.sv
hw/mcu_axil_slave.sv
hw/mcu_reg_file.sv
hw/hps_io_port.sv
hw/ms_timer.sv
hw/mcu_periph_top.sv
dv/mcu_periph_checker.sv
dv/mcu_periph_monitor.sv
dv/mcu_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, pass only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mcu_periph_top.f \
	--top-module mcu_periph_tb -o mcu_periph_sim &&
./obj_dir/mcu_periph_sim | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
